//--- hw/frame_pkg.sv
// Frame classifier shared definitions
package frame_pkg;

    // host bus word width
    localparam int word_bits = 32;

    // largest payload length a header may announce, in words
    localparam int max_frame_words = 1024;

    // pixels packed into one payload word, lowest byte first
    localparam int pixels_per_word = word_bits / 8;

    // intensity buckets, one per output word
    localparam int num_buckets = 10;

    // pixel values covered by one bucket
    // bucket is value / 26, top bucket also absorbs 234..255
    localparam int bucket_width = 26;

    // width of one saturating bucket count
    localparam int count_bits = 16;

    // watchdog width, about one million idle cycles
    localparam int default_timeout_bits = 20;

    // one pixel from the unpacker to the histogram
    typedef struct packed {
        logic [7:0] value;
        // final pixel of the frame
        logic       last;
    } pixel_beat_t;

    // full frame result from the histogram to the serializer
    // counts[0] sits in the lowest bits
    typedef struct packed {
        logic [num_buckets-1:0][count_bits-1:0] counts;
    } histogram_t;

endpackage

//--- hw/inactivity_reset.sv
// Inactivity watchdog soft reset
`timescale 1ns/10ps

module inactivity_reset #(
    parameter int timeout_bits = frame_pkg::default_timeout_bits
) (
    input  logic clock,
    input  logic reset,
    // word accepted from the host
    input  logic in_fire,
    // word delivered downstream
    input  logic out_fire,
    output logic soft_reset
);

    // idle countdown, all ones means traffic just moved
    logic [timeout_bits-1:0] idle_count;

    always_ff @(posedge clock) begin
        if (reset || in_fire || out_fire) begin
            // full timeout window again
            idle_count <= '1;
        end else begin
            // zero wraps back to all ones, so the pulse lasts one cycle
            idle_count <= idle_count - 1'b1;
        end
    end

    // hard reset passes straight through
    // expiry of the idle window adds a one cycle pulse
    assign soft_reset = reset || (idle_count == '0);

endmodule

//--- hw/frame_unpacker.sv
// Length header parser and pixel unpacker
`timescale 1ns/10ps

module frame_unpacker (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [frame_pkg::word_bits-1:0] in_data,
    input  logic                           in_valid,
    output logic                           in_ready,
    output frame_pkg::pixel_beat_t         pixel,
    output logic                           pixel_valid,
    input  logic                           pixel_ready
);

    import frame_pkg::*;

    // remaining counter must hold max_frame_words itself
    localparam int remaining_bits = $clog2(max_frame_words + 1);
    localparam int index_bits = $clog2(pixels_per_word);

    // payload words still expected, zero means next word is a header
    logic [remaining_bits-1:0] remaining;

    // one payload word being split into pixels
    logic [word_bits-1:0]  word_data;
    logic                  word_valid;
    logic                  word_is_final;
    logic [index_bits-1:0] byte_index;

    logic in_fire;
    logic beat_fire;
    logic final_beat_fire;
    logic header_ok;

    assign beat_fire = pixel_valid && pixel_ready;

    // fourth pixel leaves this cycle, buffer frees up
    assign final_beat_fire = beat_fire && (byte_index == index_bits'(pixels_per_word - 1));

    // a new word can land while the last pixel of the old one moves
    assign in_ready = !word_valid || final_beat_fire;
    assign in_fire = in_valid && in_ready;

    // zero or oversize headers are swallowed
    assign header_ok = (in_data != '0) && (in_data <= word_bits'(max_frame_words));

    always_ff @(posedge clock) begin
        if (reset) begin
            remaining <= '0;
            word_valid <= 1'b0;
            word_is_final <= 1'b0;
            byte_index <= '0;
        end else begin
            // pixel stepping first, a new word below overrides it
            if (beat_fire) begin
                byte_index <= byte_index + 1'b1;
                if (final_beat_fire) begin
                    word_valid <= 1'b0;
                end
            end

            if (in_fire) begin
                if (remaining == '0) begin
                    // header word
                    if (header_ok) begin
                        remaining <= in_data[remaining_bits-1:0];
                    end
                end else begin
                    // payload word into the buffer
                    word_data <= in_data;
                    word_valid <= 1'b1;
                    byte_index <= '0;
                    word_is_final <= (remaining == remaining_bits'(1));
                    remaining <= remaining - 1'b1;
                end
            end
        end
    end

    // lowest byte goes out first
    assign pixel.value = word_data[8*byte_index +: 8];

    // last only on the fourth pixel of the Nth word
    assign pixel.last = word_is_final && (byte_index == index_bits'(pixels_per_word - 1));

    assign pixel_valid = word_valid;

endmodule

//--- hw/intensity_histogram.sv
// Per frame intensity histogram
`timescale 1ns/10ps

module intensity_histogram (
    input  logic                   clock,
    input  logic                   reset,
    input  frame_pkg::pixel_beat_t pixel,
    input  logic                   pixel_valid,
    output logic                   pixel_ready,
    output frame_pkg::histogram_t  result,
    output logic                   result_valid,
    input  logic                   result_ready
);

    import frame_pkg::*;

    localparam int bucket_bits = $clog2(num_buckets);

    // running counts of the frame in progress
    histogram_t acc;

    // acc with the current pixel folded in
    histogram_t acc_next;

    logic [bucket_bits-1:0] bucket;
    logic [count_bits-1:0]  bucket_count;

    logic beat_fire;
    logic result_fire;

    // stall only while a finished result sits untaken
    assign pixel_ready = !result_valid || result_ready;
    assign beat_fire = pixel_valid && pixel_ready;
    assign result_fire = result_valid && result_ready;

    // bucket select by constant divide
    // 255 / 26 is 9, so 234..255 already land in the top bucket
    assign bucket = bucket_bits'(pixel.value / 8'(bucket_width));

    assign bucket_count = acc.counts[bucket];

    always_comb begin
        acc_next = acc;
        // saturate instead of wrapping
        if (beat_fire && (bucket_count != '1)) begin
            acc_next.counts[bucket] = bucket_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            acc <= '0;
            result_valid <= 1'b0;
        end else begin
            if (beat_fire && pixel.last) begin
                // frame done, hand off and start the next one from zero
                acc <= '0;
                result_valid <= 1'b1;
            end else begin
                acc <= acc_next;
                if (result_fire) begin
                    result_valid <= 1'b0;
                end
            end
        end
    end

    // result holds until the serializer takes it
    always_ff @(posedge clock) begin
        if (beat_fire && pixel.last) begin
            result <= acc_next;
        end
    end

endmodule

//--- hw/result_serializer.sv
// Histogram result serializer
`timescale 1ns/10ps

module result_serializer (
    input  logic                            clock,
    input  logic                            reset,
    input  frame_pkg::histogram_t           result,
    input  logic                            result_valid,
    output logic                            result_ready,
    output logic [frame_pkg::word_bits-1:0] out_data,
    output logic                            out_valid,
    input  logic                            out_ready
);

    import frame_pkg::*;

    localparam int index_bits = $clog2(num_buckets);

    // captured histogram being sent
    histogram_t             held;
    logic                   held_valid;
    // bucket on the bus right now
    logic [index_bits-1:0]  bucket_index;

    logic result_fire;
    logic out_fire;

    // one histogram at a time
    assign result_ready = !held_valid;
    assign result_fire = result_valid && result_ready;
    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
            bucket_index <= '0;
        end else if (result_fire) begin
            held_valid <= 1'b1;
            bucket_index <= '0;
        end else if (out_fire) begin
            if (bucket_index == index_bits'(num_buckets - 1)) begin
                // bucket nine gone, buffer free again
                held_valid <= 1'b0;
                bucket_index <= '0;
            end else begin
                bucket_index <= bucket_index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (result_fire) begin
            held <= result;
        end
    end

    assign out_valid = held_valid;

    // count zero extended to a full word
    assign out_data = word_bits'(held.counts[bucket_index]);

endmodule

//--- hw/frame_classifier_top.sv
// Frame classifier board top level
`timescale 1ns/10ps

module frame_classifier_top #(
    parameter int timeout_bits = frame_pkg::default_timeout_bits
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [frame_pkg::word_bits-1:0] in_data,
    input  logic                            in_valid,
    output logic                            upstream_stall,
    output logic [frame_pkg::word_bits-1:0] out_data,
    output logic                            out_valid,
    input  logic                            downstream_stall
);

    import frame_pkg::*;

    // board stall pins against internal ready
    logic in_ready;
    logic out_ready;

    logic soft_reset;
    logic in_fire;
    logic out_fire;

    pixel_beat_t pixel;
    logic        pixel_valid;
    logic        pixel_ready;

    histogram_t result;
    logic       result_valid;
    logic       result_ready;

    assign upstream_stall = !in_ready;
    assign out_ready = !downstream_stall;

    // any traffic at either end keeps the watchdog quiet
    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    inactivity_reset #(.timeout_bits(timeout_bits)) watchdog0 (
        .clock(clock), .reset(reset),
        .in_fire(in_fire), .out_fire(out_fire),
        .soft_reset(soft_reset)
    );

    frame_unpacker unpacker0 (
        .clock(clock), .reset(soft_reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .pixel(pixel), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready)
    );

    // stands in for the classifier model
    intensity_histogram histogram0 (
        .clock(clock), .reset(soft_reset),
        .pixel(pixel), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
        .result(result), .result_valid(result_valid), .result_ready(result_ready)
    );

    result_serializer serializer0 (
        .clock(clock), .reset(soft_reset),
        .result(result), .result_valid(result_valid), .result_ready(result_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

//--- verification/frame_classifier_assertions.sv
// Frame classifier protocol assertions
`timescale 1ns/10ps

module frame_classifier_assertions (
    input logic                            clock,
    input logic                            reset,
    input logic                            soft_reset,
    input logic                            pixel_valid,
    input frame_pkg::histogram_t           result,
    input logic                            result_valid,
    input logic                            result_ready,
    input logic [frame_pkg::word_bits-1:0] out_data,
    input logic                            out_valid,
    input logic                            downstream_stall
);

    // stalled output word stays on the bus
    property out_held_while_stalled;
        @(posedge clock) disable iff (soft_reset)
        out_valid && downstream_stall |=> out_valid && $stable(out_data);
    endproperty

    // every valid cleared by hard reset
    property valids_low_in_reset;
        @(posedge clock)
        reset |=> !pixel_valid && !result_valid && !out_valid;
    endproperty

    // histogram result frozen until the serializer takes it
    property result_held_until_taken;
        @(posedge clock) disable iff (soft_reset)
        result_valid && !result_ready |=> result_valid && $stable(result);
    endproperty

    assert property (out_held_while_stalled)
        else $error("out_valid or out_data changed under downstream_stall");
    assert property (valids_low_in_reset)
        else $error("valid high after a reset cycle");
    assert property (result_held_until_taken)
        else $error("held histogram result changed before transfer");

endmodule

bind frame_classifier_top frame_classifier_assertions assertions0 (
    .clock(clock), .reset(reset), .soft_reset(soft_reset),
    .pixel_valid(pixel_valid),
    .result(result), .result_valid(result_valid), .result_ready(result_ready),
    .out_data(out_data), .out_valid(out_valid), .downstream_stall(downstream_stall)
);

//--- verification/frame_classifier_tb.sv
// Frame classifier testbench
`timescale 1ns/10ps

module frame_classifier_tb;

    import frame_pkg::*;

    typedef logic [word_bits-1:0] word_q_t[$];

    localparam logic [31:0] seed = 32'h6881_f5bb;
    // per word accept and per group drain limits, in cycles
    localparam int accept_limit = 2000;
    localparam int drain_limit = 4000;

    logic                 clock;
    logic                 reset;
    logic [word_bits-1:0] in_data;
    logic                 in_valid;
    logic                 upstream_stall;
    logic [word_bits-1:0] out_data;
    logic                 out_valid;
    logic                 downstream_stall = 1'b0;

    // 0 never stall, 1 random, 2 long bursts plus random
    logic [1:0]  stall_mode = 2'd0;
    logic [31:0] rand_state;
    logic [31:0] stall_state = ~seed;
    logic [7:0]  burst_count = 8'd0;
    int          stall_run = 0;
    int          max_stall_run = 0;

    word_q_t              frame_words;
    logic [word_bits-1:0] expected[$];
    logic [word_bits-1:0] expected_word;
    string                test_name;
    int                   errors;
    int                   checks;
    bit                   timed_out;

    frame_classifier_top #(.timeout_bits(8)) dut0 (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .upstream_stall(upstream_stall),
        .out_data(out_data), .out_valid(out_valid), .downstream_stall(downstream_stall)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected bucket counts, four pixels per word, low byte first
    function automatic histogram_t histogram_of(input word_q_t words);
        histogram_t h;
        logic [7:0] value;
        int         bucket;
        h = '0;
        foreach (words[i]) begin
            for (int k = 0; k < 4; k++) begin
                value = words[i][8*k +: 8];
                // walk up the 26 wide ranges, the top bucket keeps the rest
                bucket = 0;
                while ((bucket < num_buckets - 1) &&
                       (int'(value) >= (bucket + 1) * bucket_width)) begin
                    bucket++;
                end
                h.counts[bucket] = h.counts[bucket] + 16'd1;
            end
        end
        return h;
    endfunction

    task report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("ERROR: timeout, %s in test %s", what, test_name);
    endtask

    // random payload words
    task fill_frame(input int len);
        frame_words.delete();
        repeat (len) begin
            rand_state = lcg_next(rand_state);
            frame_words.push_back(rand_state);
        end
    endtask

    // ten result words for the current frame, bucket 0 first
    task expect_frame();
        histogram_t h;
        h = histogram_of(frame_words);
        for (int b = 0; b < num_buckets; b++) begin
            expected.push_back(word_bits'(h.counts[b]));
        end
    endtask

    // hold the word until an edge sees upstream_stall low
    task send_word(input logic [word_bits-1:0] data);
        int waited;
        bit accepted;
        if (timed_out) begin
            return;
        end
        in_data <= data;
        in_valid <= 1'b1;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < accept_limit) begin
            @(posedge clock);
            waited++;
            accepted = !upstream_stall;
        end
        if (!accepted) begin
            report_timeout("input word never accepted");
        end
    endtask

    // header then payload, in_valid stays up for back to back frames
    task send_frame(input int len);
        fill_frame(len);
        expect_frame();
        send_word(len);
        foreach (frame_words[i]) begin
            send_word(frame_words[i]);
        end
    endtask

    task idle_bus(input int cycles);
        in_valid <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    // every expected word must come out
    task wait_drained();
        int waited;
        bit drained;
        if (timed_out) begin
            return;
        end
        waited = 0;
        drained = (expected.size() == 0);
        while (!drained && waited < drain_limit) begin
            @(posedge clock);
            waited++;
            drained = (expected.size() == 0);
        end
        if (!drained) begin
            report_timeout("result words missing");
        end
    endtask

    task finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // downstream back-pressure, bursts of 128 cycles in mode 2
    always @(posedge clock) begin
        stall_state = lcg_next(stall_state);
        burst_count = burst_count + 8'd1;
        case (stall_mode)
            2'd1: downstream_stall <= stall_state[16];
            2'd2: downstream_stall <= burst_count[7] || stall_state[16];
            default: downstream_stall <= 1'b0;
        endcase
    end

    // longest run of upstream_stall seen
    always @(posedge clock) begin
        if (upstream_stall) begin
            stall_run = stall_run + 1;
            if (stall_run > max_stall_run) begin
                max_stall_run = stall_run;
            end
        end else begin
            stall_run = 0;
        end
    end

    // output word transfers on an edge with out_valid and no stall
    always @(posedge clock) begin
        if (!reset && out_valid && !downstream_stall) begin
            checks++;
            assert (expected.size() != 0) else begin
                errors++;
                $display("ERROR: extra output word %0d in test %s", out_data, test_name);
            end
            if (expected.size() != 0) begin
                expected_word = expected.pop_front();
                assert (out_data == expected_word) else begin
                    errors++;
                    $display("MISMATCH test %s expected %0d actual %0d",
                             test_name, expected_word, out_data);
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        rand_state = seed;

        // reset state, quiet during reset and until first input
        test_name = "reset state";
        for (int c = 0; c < 16; c++) begin
            @(posedge clock);
            if (c >= 1) begin
                assert (!out_valid && !upstream_stall) else begin
                    errors++;
                    $display("ERROR: out_valid or upstream_stall high during reset");
                end
            end
        end
        reset <= 1'b0;
        repeat (10) begin
            @(posedge clock);
            assert (!out_valid && !upstream_stall) else begin
                errors++;
                $display("ERROR: out_valid or upstream_stall high before first input");
            end
        end

        test_name = "single frame";
        send_frame(16);
        idle_bus(1);
        wait_drained();

        // lengths 1..64, no gaps between frames
        test_name = "back to back";
        repeat (5) begin
            rand_state = lcg_next(rand_state);
            send_frame(1 + int'(rand_state[21:16]));
        end
        idle_bus(1);
        wait_drained();

        test_name = "back pressure";
        stall_mode <= 2'd1;
        repeat (3) begin
            rand_state = lcg_next(rand_state);
            send_frame(1 + int'(rand_state[21:16]));
        end
        // long bursts fill the chain back to the host
        stall_mode <= 2'd2;
        repeat (8) send_frame(8);
        idle_bus(1);
        wait_drained();
        stall_mode <= 2'd0;
        assert (max_stall_run >= 32) else begin
            errors++;
            $display("ERROR: upstream_stall never held through a long downstream stall");
        end

        // zero header swallowed, no output of its own
        test_name = "zero header";
        send_word(32'd0);
        send_frame(12);
        idle_bus(1);
        wait_drained();

        // half frame, then idle past the 255 cycle window
        test_name = "watchdog";
        fill_frame(16);
        send_word(32'd16);
        for (int i = 0; i < 8; i++) begin
            send_word(frame_words[i]);
        end
        idle_bus(300);
        send_frame(16);
        idle_bus(20);
        wait_drained();

        finish_run();
    end

endmodule

//--- src.f
hw/frame_pkg.sv
hw/inactivity_reset.sv
hw/frame_unpacker.sv
hw/intensity_histogram.sv
hw/result_serializer.sv
hw/frame_classifier_top.sv
verification/frame_classifier_assertions.sv
verification/frame_classifier_tb.sv

//--- Makefile
# Verilator build and run for the frame classifier testbench
TOP := frame_classifier_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

# verdict comes from the log, the simulator exit code is not used
run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run FAILED"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "run FAILED, simulation ended early"; exit 1; \
	fi
	@echo "run PASSED"

clean:
	rm -rf obj_dir $(LOG)
